// File: Makefile
TOP = layer_renderer_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --timescale 1ns/100ps -f list.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

// File: fetch_sequencer.sv
// Fetch sequencer: reads map and pattern words over the bus and hands them to the pixel stage
module fetch_sequencer
    import layer_render_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       line_render_start,
    input  bus_word_t  bus_rddata,
    input  logic       bus_ack,
    input  bus_addr_t  map_addr,
    input  bus_addr_t  tile_addr,
    input  logic [7:0] cur_attr,
    input  logic [3:0] tile_row_flipped,
    input  logic [1:0] rows_per_word_minus1,
    input  logic [1:0] words_per_row_minus1,
    input  logic       scrolled_htile_lsb,
    input  logic       render_busy,
    input  logic       line_done,
    output bus_addr_t  bus_addr,
    output logic       bus_strobe,
    output logic [7:0] htile_cnt,
    output logic [1:0] word_cnt,
    output bus_word_t  map_word,
    output bus_word_t  render_data,
    output logic [7:0] render_attr,
    output logic       render_start
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH_MAP,
        ST_WAIT_MAP,
        ST_FETCH_TILE,
        ST_WAIT_TILE,
        ST_HANDOVER
    } state_t;

    state_t    state;
    logic      bus_req;
    bus_word_t tile_data;

    // Request is held until the ack cycle
    assign bus_strobe = bus_req && !bus_ack;

    ////////////////////////////////////////////////////////////
    // Hand-over to the pixel stage
    ////////////////////////////////////////////////////////////

    // Entry decode still refers to the current tile in this state
    assign render_start = (state == ST_HANDOVER) && !render_busy && !line_done;
    assign render_attr  = cur_attr;

    // Words holding two rows give the flipped row's half
    always_comb begin
        if (rows_per_word_minus1 != 2'd0) begin
            render_data = {16'h0000, tile_row_flipped[0] ? tile_data[31:16] : tile_data[15:0]};
        end else begin
            render_data = tile_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            bus_req   <= 1'b0;
            htile_cnt <= '0;
            word_cnt  <= '0;
        end else begin
            case (state)
                ST_FETCH_MAP: begin
                    bus_addr <= map_addr;
                    bus_req  <= 1'b1;
                    state    <= ST_WAIT_MAP;
                end
                ST_WAIT_MAP: begin
                    if (bus_ack) begin
                        map_word <= bus_rddata;
                        bus_req  <= 1'b0;
                        state    <= ST_FETCH_TILE;
                    end
                end
                ST_FETCH_TILE: begin
                    bus_addr <= tile_addr;
                    bus_req  <= 1'b1;
                    state    <= ST_WAIT_TILE;
                end
                ST_WAIT_TILE: begin
                    if (bus_ack) begin
                        tile_data <= bus_rddata;
                        bus_req   <= 1'b0;
                        state     <= ST_HANDOVER;
                    end
                end
                ST_HANDOVER: begin
                    if (line_done) begin
                        state     <= ST_IDLE;
                        htile_cnt <= '0;
                        word_cnt  <= '0;
                    end else if (!render_busy) begin
                        if (word_cnt == words_per_row_minus1) begin
                            word_cnt  <= '0;
                            htile_cnt <= htile_cnt + 8'd1;
                            // New map word only after the odd entry of a pair
                            state     <= scrolled_htile_lsb ? ST_FETCH_MAP : ST_FETCH_TILE;
                        end else begin
                            word_cnt <= word_cnt + 2'd1;
                            state    <= ST_FETCH_TILE;
                        end
                    end
                end
                default: begin
                end
            endcase

            if (line_render_start) begin
                htile_cnt <= '0;
                word_cnt  <= '0;
                if (state == ST_IDLE) begin
                    // Counters are already zero in idle, so column 0 can go out now
                    bus_addr <= map_addr;
                    bus_req  <= 1'b1;
                    state    <= ST_WAIT_MAP;
                end else begin
                    state <= ST_FETCH_MAP;
                end
            end
        end
    end

endmodule

// File: layer_geometry.sv
// Layer geometry decode: word and pixel counts per mode, scrolled map row, line start index
module layer_geometry
    import layer_render_pkg::*;
(
    input  logic [8:0]   line_idx,
    input  color_depth_t color_depth,
    input  logic         tile_width,
    input  logic         tile_height,
    input  logic [1:0]   map_height,
    input  logic [11:0]  vscroll,
    input  logic [11:0]  hscroll,
    output logic [4:0]   pixels_per_word_minus1,
    output logic [1:0]   rows_per_word_minus1,
    output logic [1:0]   words_per_row_minus1,
    output logic [3:0]   tile_row,
    output logic [7:0]   map_row,
    output lb_idx_t      lb_start,
    output logic [7:0]   htile_offset
);

    logic [11:0] scrolled_line;
    logic [7:0]  vmap_idx;
    logic [3:0]  subtile_hscroll;

    // Counts per pattern word by depth and tile width
    always_comb begin
        case (color_depth)
            DEPTH_2BPP: begin
                pixels_per_word_minus1 = tile_width ? 5'd15 : 5'd7;
                rows_per_word_minus1   = tile_width ? 2'd0 : 2'd1;
                words_per_row_minus1   = 2'd0;
            end
            DEPTH_4BPP: begin
                pixels_per_word_minus1 = 5'd7;
                rows_per_word_minus1   = 2'd0;
                words_per_row_minus1   = tile_width ? 2'd1 : 2'd0;
            end
            default: begin
                pixels_per_word_minus1 = 5'd3;
                rows_per_word_minus1   = 2'd0;
                words_per_row_minus1   = tile_width ? 2'd3 : 2'd1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Vertical scroll and map row wrap
    ////////////////////////////////////////////////////////////

    assign scrolled_line = {3'b000, line_idx} + vscroll;
    assign tile_row      = scrolled_line[3:0];
    assign vmap_idx      = tile_height ? scrolled_line[11:4] : scrolled_line[10:3];

    always_comb begin
        case (map_height)
            2'd0:    map_row = {3'b000, vmap_idx[4:0]};
            2'd1:    map_row = {2'b00, vmap_idx[5:0]};
            2'd2:    map_row = {1'b0, vmap_idx[6:0]};
            default: map_row = vmap_idx;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Horizontal scroll, whole tiles and sub-tile remainder
    ////////////////////////////////////////////////////////////

    assign htile_offset    = tile_width ? hscroll[11:4] : hscroll[10:3];
    assign subtile_hscroll = tile_width ? hscroll[3:0] : {1'b0, hscroll[2:0]};

    // First pixels land at negative indices and fall outside the line
    assign lb_start = lb_idx_t'(0) - lb_idx_t'(subtile_hscroll);

endmodule

// File: layer_render_macros.svh
// Layer renderer constants for bus, line buffer and base register widths
`ifndef LAYER_RENDER_MACROS_SVH
`define LAYER_RENDER_MACROS_SVH

// Video memory bus, word addressed
`define BUS_ADDR_W  15
`define BUS_DATA_W  32

// Line buffer index and visible width
`define LB_IDX_W    10
`define LINE_PIXELS 640

// Map and tile base registers count in blocks of 128 words
`define BASE_SHIFT  7

`endif

// File: layer_render_pkg.sv
// Shared types of the tiled layer renderer
`include "layer_render_macros.svh"

package layer_render_pkg;

    // Tile color depth, 0 is not supported
    typedef enum logic [1:0] {
        DEPTH_2BPP = 2'd1,
        DEPTH_4BPP = 2'd2,
        DEPTH_8BPP = 2'd3
    } color_depth_t;

    // Video memory
    typedef logic [`BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [`BUS_DATA_W-1:0] bus_word_t;

    // Map entry: [15:12] palette, [11] vflip, [10] hflip, [9:0] tile
    typedef logic [15:0] map_entry_t;
    typedef logic [9:0]  tile_idx_t;

    // Line buffer
    typedef logic [`LB_IDX_W-1:0] lb_idx_t;
    typedef logic [7:0]           pixel_t;

endpackage

// File: layer_renderer.sv
// Tiled layer renderer top: renders one background line from video memory into the line buffer
module layer_renderer
    import layer_render_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    // Line control and layer registers
    input  logic [8:0]   line_idx,
    input  logic         line_render_start,
    input  color_depth_t color_depth,
    input  logic         tile_height,
    input  logic         tile_width,
    input  logic [1:0]   map_height,
    input  logic [1:0]   map_width,
    input  logic [7:0]   map_baseaddr,
    input  logic [7:0]   tile_baseaddr,
    input  logic [11:0]  hscroll,
    input  logic [11:0]  vscroll,

    // Video memory bus
    output bus_addr_t    bus_addr,
    input  bus_word_t    bus_rddata,
    output logic         bus_strobe,
    input  logic         bus_ack,

    // Line buffer
    output lb_idx_t      linebuf_wridx,
    output pixel_t       linebuf_wrdata,
    output logic         linebuf_wren
);

    // Geometry
    logic [4:0] pixels_per_word_minus1;
    logic [1:0] rows_per_word_minus1;
    logic [1:0] words_per_row_minus1;
    logic [3:0] tile_row;
    logic [7:0] map_row;
    lb_idx_t    lb_start;
    logic [7:0] htile_offset;

    // Addressing and entry decode
    bus_addr_t  map_addr;
    bus_addr_t  tile_addr;
    logic [7:0] cur_attr;
    logic [3:0] tile_row_flipped;
    logic       hflip;
    logic       scrolled_htile_lsb;

    // Fetch to pixel stage
    logic [7:0] htile_cnt;
    logic [1:0] word_cnt;
    bus_word_t  map_word;
    bus_word_t  render_data;
    logic [7:0] render_attr;
    logic       render_start;
    logic       render_busy;
    logic       line_done;

    layer_geometry  geometry_i (.*);
    tile_addr_gen   addr_gen_i (.*);
    fetch_sequencer fetch_i    (.*);
    pixel_renderer  pixel_i    (.*);

endmodule

// File: layer_renderer_tb.sv
// Testbench for the tiled layer renderer with video memory model, bus responder and pixel checker
`include "layer_render_macros.svh"

module layer_renderer_tb
    import layer_render_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LINE_TIMEOUT = 40000;
    localparam int IDLE_TIMEOUT = 200;
    localparam int QUIET_CYCLES = 8;

    logic         clk;
    logic         rst;
    logic [8:0]   line_idx;
    logic         line_render_start;
    color_depth_t color_depth;
    logic         tile_height;
    logic         tile_width;
    logic [1:0]   map_height;
    logic [1:0]   map_width;
    logic [7:0]   map_baseaddr;
    logic [7:0]   tile_baseaddr;
    logic [11:0]  hscroll;
    logic [11:0]  vscroll;
    bus_addr_t    bus_addr;
    bus_word_t    bus_rddata;
    logic         bus_strobe;
    logic         bus_ack;
    lb_idx_t      linebuf_wridx;
    pixel_t       linebuf_wrdata;
    logic         linebuf_wren;

    bus_word_t    vmem [0:32767];
    logic [31:0]  lfsr_state = 32'h83b1243a;
    int           write_count = 0;
    int           expected_writes = 0;
    int           sub_scroll = 0;
    int           check_count = 0;
    int           error_count = 0;
    int           line_count = 0;
    int           idle_run = 0;
    int           ack_delay = -1;
    logic         timed_out = 1'b0;
    lb_idx_t      last_wridx;
    lb_idx_t      exp_idx;
    pixel_t       exp_pixel;

    layer_renderer dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Color of write number n of the current line
    function automatic pixel_t expected_pixel(input int n);
        int          tw, th, bpp, mapw, maph, col, row, px, py, map_idx;
        int          tile, byte_addr, word_addr, ppb, bit_pos;
        logic [15:0] entry;
        bus_word_t   word;
        pixel_t      raw;
        tw      = tile_width ? 16 : 8;
        th      = tile_height ? 16 : 8;
        bpp     = (color_depth == DEPTH_2BPP) ? 2 : (color_depth == DEPTH_4BPP) ? 4 : 8;
        mapw    = 32 << map_width;
        maph    = 32 << map_height;
        col     = int'(hscroll) - int'(hscroll) % tw + n;
        row     = (int'(line_idx) + int'(vscroll)) % 4096;
        px      = col % tw;
        py      = row % th;
        map_idx = ((row / th) % maph) * mapw + (col / tw) % mapw;
        word    = vmem[(int'(map_baseaddr) * 128 + map_idx / 2) % 32768];
        entry   = (map_idx % 2 == 1) ? word[31:16] : word[15:0];
        if (entry[10]) begin
            px = tw - 1 - px;
        end
        if (entry[11]) begin
            py = th - 1 - py;
        end
        // Rows are packed bytes with the leftmost pixel in the high bits of a byte
        tile      = int'(entry[9:0]);
        ppb       = 8 / bpp;
        byte_addr = py * (tw * bpp / 8) + px / ppb;
        word_addr = (int'(tile_baseaddr) * 128 + tile * (tw * th * bpp / 32) + byte_addr / 4)
                    % 32768;
        bit_pos   = (byte_addr % 4) * 8 + (ppb - 1 - px % ppb) * bpp;
        raw       = 8'((vmem[word_addr] >> bit_pos) & ((32'd1 << bpp) - 32'd1));
        if (raw != 8'h00 && raw < 8'h10) begin
            raw = {entry[15:12], raw[3:0]};
        end
        return raw;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus responder and write checker
    ////////////////////////////////////////////////////////////

    initial begin
        bus_ack    = 1'b0;
        bus_rddata = '0;
        forever begin
            @(negedge clk);
            if (bus_ack) begin
                bus_ack  = 1'b0;
                idle_run = 0;
            end else if (bus_strobe) begin
                idle_run = 0;
                if (ack_delay < 0) begin
                    ack_delay = int'(take_bits(2));
                end
                if (ack_delay == 0) begin
                    bus_rddata = vmem[bus_addr];
                    bus_ack    = 1'b1;
                    ack_delay  = -1;
                end else begin
                    ack_delay--;
                end
            end else begin
                idle_run++;
            end
        end
    end

    always @(negedge clk) begin
        if (linebuf_wren) begin
            if (write_count >= expected_writes) begin
                $display("Line buffer write outside a line, index 0x%03h", linebuf_wridx);
                error_count++;
            end else begin
                exp_idx   = lb_idx_t'(write_count - sub_scroll);
                exp_pixel = expected_pixel(write_count);
                check_count++;
                if (linebuf_wridx !== exp_idx) begin
                    $display("** Error linebuf_wridx: write %0d got 0x%03h expected 0x%03h",
                             write_count, linebuf_wridx, exp_idx);
                    error_count++;
                end
                if (linebuf_wrdata !== exp_pixel) begin
                    $display("** Error linebuf_wrdata: write %0d got 0x%02h expected 0x%02h",
                             write_count, linebuf_wrdata, exp_pixel);
                    error_count++;
                end
            end
            last_wridx = linebuf_wridx;
            write_count++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    task automatic finish_run();
        $display("Lines %0d, writes checked %0d, errors %0d", line_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic set_config(input color_depth_t depth, input logic tw, input logic th,
                              input logic [1:0] mw, input logic [1:0] mh,
                              input logic [7:0] mbase, input logic [7:0] tbase,
                              input logic [11:0] hs, input logic [11:0] vs,
                              input logic [8:0] line);
        color_depth   = depth;
        tile_width    = tw;
        tile_height   = th;
        map_width     = mw;
        map_height    = mh;
        map_baseaddr  = mbase;
        tile_baseaddr = tbase;
        hscroll       = hs;
        vscroll       = vs;
        line_idx      = line;
        sub_scroll    = int'(hs) % (tw ? 16 : 8);
    endtask

    task automatic random_config();
        color_depth_t depth;
        logic [31:0]  bits;
        logic [11:0]  hs;
        logic [11:0]  vs;
        logic [8:0]   line;
        depth = color_depth_t'(2'd1 + 2'(take_bits(2) % 3));
        bits  = take_bits(32);
        hs    = 12'(take_bits(12));
        vs    = 12'(take_bits(12));
        line  = 9'(take_bits(9));
        set_config(depth, bits[0], bits[1], bits[3:2], bits[5:4], bits[13:6], bits[21:14],
                   hs, vs, line);
    endtask

    // One line from start pulse until the fetch side is quiet again
    task automatic run_line(input string name);
        int cycles;
        if (timed_out) begin
            return;
        end
        @(negedge clk);
        $display("Rendering %s", name);
        write_count       = 0;
        expected_writes   = `LINE_PIXELS + sub_scroll;
        line_render_start = 1'b1;
        @(negedge clk);
        line_render_start = 1'b0;
        cycles = 0;
        while (write_count < expected_writes && cycles < LINE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (write_count < expected_writes) begin
            $display("Timeout in %s after %0d of %0d writes", name, write_count, expected_writes);
            error_count++;
            timed_out = 1'b1;
            return;
        end
        idle_run = 0;
        cycles   = 0;
        while (idle_run < QUIET_CYCLES && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (idle_run < QUIET_CYCLES) begin
            $display("Timeout in %s, bus still busy after the last write", name);
            error_count++;
            timed_out = 1'b1;
            return;
        end
        if (write_count != expected_writes) begin
            $display("%s produced %0d writes instead of %0d", name, write_count, expected_writes);
            error_count++;
        end
        if (last_wridx !== lb_idx_t'(`LINE_PIXELS - 1)) begin
            $display("** Error linebuf_wridx: last write 0x%03h expected 0x%03h",
                     last_wridx, lb_idx_t'(`LINE_PIXELS - 1));
            error_count++;
        end
        line_count++;
    endtask

    initial begin
        rst               = 1'b1;
        line_render_start = 1'b0;
        set_config(DEPTH_8BPP, 1'b0, 1'b0, 2'd0, 2'd0, 8'h00, 8'h00, 12'd0, 12'd0, 9'd0);
        for (int a = 0; a < 32768; a++) begin
            vmem[a] = take_bits(32);
        end
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Quiet after reset
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            if (linebuf_wren !== 1'b0) begin
                $display("** Error linebuf_wren: got 0x%0h expected 0x0", linebuf_wren);
                error_count++;
            end
            if (bus_strobe !== 1'b0) begin
                $display("** Error bus_strobe: got 0x%0h expected 0x0", bus_strobe);
                error_count++;
            end
        end

        set_config(DEPTH_8BPP, 1'b0, 1'b0, 2'd1, 2'd0, 8'h20, 8'h60, 12'd0, 12'd0, 9'd37);
        run_line("8bpp 8x8 unscrolled");
        set_config(DEPTH_4BPP, 1'b1, 1'b1, 2'd0, 2'd0, 8'h05, 8'h90, 12'd1333, 12'd700, 9'd123);
        run_line("4bpp 16x16 wrapped scroll");
        set_config(DEPTH_2BPP, 1'b0, 1'b1, 2'd2, 2'd1, 8'hc3, 8'h11, 12'd2053, 12'd389, 9'd301);
        run_line("2bpp width 8");
        set_config(DEPTH_2BPP, 1'b1, 1'b0, 2'd3, 2'd3, 8'h7e, 8'h2a, 12'd3891, 12'd3000, 9'd479);
        run_line("2bpp width 16");

        for (int i = 0; i < 5; i++) begin
            random_config();
            run_line($sformatf("random line %0d", i));
        end
        finish_run();
    end

endmodule

// File: list.f
+incdir+.
layer_render_pkg.sv
layer_geometry.sv
tile_addr_gen.sv
fetch_sequencer.sv
pixel_renderer.sv
layer_renderer.sv
layer_renderer_tb.sv

// File: pixel_renderer.sv
// Pixel renderer: unpacks pattern words into colors and writes them to the line buffer
`include "layer_render_macros.svh"

module pixel_renderer
    import layer_render_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         line_render_start,
    input  logic         render_start,
    input  bus_word_t    render_data,
    input  logic [7:0]   render_attr,
    input  logic         hflip,
    input  color_depth_t color_depth,
    input  logic [4:0]   pixels_per_word_minus1,
    input  lb_idx_t      lb_start,
    output logic         render_busy,
    output logic         line_done,
    output lb_idx_t      linebuf_wridx,
    output pixel_t       linebuf_wrdata,
    output logic         linebuf_wren
);

    logic [4:0] xcnt_r;
    logic       busy_r;
    bus_word_t  data_r;
    logic [3:0] pal_r;
    logic       flip_r;
    lb_idx_t    wridx_r;

    logic [4:0] cur_x;
    bus_word_t  cur_data;
    logic [3:0] cur_pal;
    logic       cur_flip;
    logic [3:0] pix_pos;
    logic [4:0] bit_pos;
    pixel_t     raw_color;
    pixel_t     color;
    logic       active;

    assign line_done   = (wridx_r == lb_idx_t'(`LINE_PIXELS));
    assign render_busy = busy_r;
    assign active      = !line_done && (busy_r || render_start);

    ////////////////////////////////////////////////////////////
    // Pixel select
    ////////////////////////////////////////////////////////////

    // First pixel of a word comes straight from the hand-over
    always_comb begin
        cur_x    = render_start ? 5'd0 : xcnt_r;
        cur_data = render_start ? render_data : data_r;
        cur_pal  = render_start ? render_attr[7:4] : pal_r;
        cur_flip = render_start ? hflip : flip_r;
    end

    // Mirror within the word's own pixel count
    assign pix_pos = cur_flip ? (cur_x[3:0] ^ pixels_per_word_minus1[3:0]) : cur_x[3:0];

    // Leftmost pixel sits in the high bits of each byte
    always_comb begin
        case (color_depth)
            DEPTH_2BPP: begin
                bit_pos   = {pix_pos[3:2], ~pix_pos[1:0], 1'b0};
                raw_color = {6'b000000, cur_data[bit_pos +: 2]};
            end
            DEPTH_4BPP: begin
                bit_pos   = {pix_pos[2:1], ~pix_pos[0], 2'b00};
                raw_color = {4'h0, cur_data[bit_pos +: 4]};
            end
            default: begin
                bit_pos   = {pix_pos[1:0], 3'b000};
                raw_color = cur_data[bit_pos +: 8];
            end
        endcase
    end

    // Palette offset, color 0 stays transparent
    assign color = (raw_color[7:4] == 4'h0 && raw_color[3:0] != 4'h0) ?
                   {cur_pal, raw_color[3:0]} : raw_color;

    ////////////////////////////////////////////////////////////
    // Counters and line buffer write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            xcnt_r       <= '0;
            busy_r       <= 1'b0;
            wridx_r      <= '0;
            linebuf_wren <= 1'b0;
        end else begin
            linebuf_wren <= active;
            if (active) begin
                wridx_r <= wridx_r + 1'b1;
                if (cur_x == pixels_per_word_minus1) begin
                    busy_r <= 1'b0;
                    xcnt_r <= '0;
                end else begin
                    busy_r <= 1'b1;
                    xcnt_r <= cur_x + 5'd1;
                end
            end
            if (line_render_start) begin
                wridx_r <= lb_start;
                busy_r  <= 1'b0;
                xcnt_r  <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (render_start) begin
            data_r <= render_data;
            pal_r  <= render_attr[7:4];
            flip_r <= hflip;
        end
        if (active) begin
            linebuf_wridx  <= wridx_r;
            linebuf_wrdata <= color;
        end
    end

endmodule

// File: tile_addr_gen.sv
// Tile address generator: map entry address, entry decode and pattern word address
`include "layer_render_macros.svh"

module tile_addr_gen
    import layer_render_pkg::*;
(
    input  color_depth_t color_depth,
    input  logic         tile_width,
    input  logic         tile_height,
    input  logic [1:0]   map_width,
    input  logic [7:0]   map_baseaddr,
    input  logic [7:0]   tile_baseaddr,
    input  logic [7:0]   map_row,
    input  logic [3:0]   tile_row,
    input  logic [7:0]   htile_cnt,
    input  logic [1:0]   word_cnt,
    input  logic [7:0]   htile_offset,
    input  bus_word_t    map_word,
    output bus_addr_t    map_addr,
    output bus_addr_t    tile_addr,
    output logic [7:0]   cur_attr,
    output logic [3:0]   tile_row_flipped,
    output logic         hflip,
    output logic         scrolled_htile_lsb
);

    logic [7:0]  scrolled_htile;
    logic [15:0] map_idx;
    map_entry_t  entry;
    tile_idx_t   tile_idx;
    logic        vflip;
    logic [1:0]  word_flipped;
    logic [3:0]  r;
    bus_addr_t   pattern_offset;

    assign scrolled_htile     = htile_cnt + htile_offset;
    assign scrolled_htile_lsb = scrolled_htile[0];

    // Row-major map index, column wrapped by map width
    always_comb begin
        case (map_width)
            2'd0:    map_idx = {3'b000, map_row, scrolled_htile[4:0]};
            2'd1:    map_idx = {2'b00, map_row, scrolled_htile[5:0]};
            2'd2:    map_idx = {1'b0, map_row, scrolled_htile[6:0]};
            default: map_idx = {map_row, scrolled_htile};
        endcase
    end

    // Two entries per word
    assign map_addr = (bus_addr_t'(map_baseaddr) << `BASE_SHIFT) + bus_addr_t'(map_idx[15:1]);

    assign entry    = map_idx[0] ? map_word[31:16] : map_word[15:0];
    assign tile_idx = entry[9:0];
    assign hflip    = entry[10];
    assign vflip    = entry[11];
    assign cur_attr = entry[15:8];

    assign tile_row_flipped = vflip ? ~tile_row : tile_row;
    assign word_flipped     = hflip ? ~word_cnt : word_cnt;
    assign r                = tile_row_flipped;

    ////////////////////////////////////////////////////////////
    // Pattern word offset within the tile area
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (color_depth)
            DEPTH_2BPP: begin
                case ({tile_width, tile_height})
                    2'b00:   pattern_offset = {3'b000, tile_idx, r[2:1]};
                    2'b01:   pattern_offset = {2'b00, tile_idx, r[3:1]};
                    2'b10:   pattern_offset = {2'b00, tile_idx, r[2:0]};
                    default: pattern_offset = {1'b0, tile_idx, r[3:0]};
                endcase
            end
            DEPTH_4BPP: begin
                case ({tile_width, tile_height})
                    2'b00:   pattern_offset = {2'b00, tile_idx, r[2:0]};
                    2'b01:   pattern_offset = {1'b0, tile_idx, r[3:0]};
                    2'b10:   pattern_offset = {1'b0, tile_idx, r[2:0], word_flipped[0]};
                    default: pattern_offset = {tile_idx, r[3:0], word_flipped[0]};
                endcase
            end
            default: begin
                case ({tile_width, tile_height})
                    2'b00:   pattern_offset = {1'b0, tile_idx, r[2:0], word_flipped[0]};
                    2'b01:   pattern_offset = {tile_idx, r[3:0], word_flipped[0]};
                    2'b10:   pattern_offset = {tile_idx, r[2:0], word_flipped};
                    default: pattern_offset = {tile_idx[8:0], r[3:0], word_flipped};
                endcase
            end
        endcase
    end

    assign tile_addr = (bus_addr_t'(tile_baseaddr) << `BASE_SHIFT) + pattern_offset;

endmodule
